// ==== build.f ====
+incdir+hw
hw/ctrl_pkg.sv
hw/frame_if.sv
hw/rx_skid.sv
hw/frame_parser.sv
hw/stream_ctrl.sv
hw/status_reply.sv
hw/audio_ctrl_top.sv
test/tb_audio_ctrl.sv

// ==== hw/audio_ctrl_top.sv ====
/*
 * Top of the host control path. Host bytes pass the skid buffer and parser
 * into the controller, which drives samples, config and the status reply.
 */
module audio_ctrl_top (
    input  logic               clk,
    input  logic               reset_i,
    // Host input
    input  logic               host_valid_i,
    output logic               host_ready_o,
    input  ctrl_pkg::byte_t    host_data_i,
    // Status reply to the host
    output logic               reply_valid_o,
    input  logic               reply_ready_i,
    output ctrl_pkg::byte_t    reply_data_o,
    // Samples to the transmitter
    output logic               sample_valid_o,
    input  logic               sample_ready_i,
    output ctrl_pkg::byte_t    sample_data_o,
    // Current configuration
    output ctrl_pkg::io_type_t io_type_o,
    output ctrl_pkg::rate_e    rate_o,
    output ctrl_pkg::depth_e   depth_o,
    input  logic               output_busy_i,
    output logic               err_o
);
    import ctrl_pkg::*;

    logic       skid_valid;
    logic       skid_ready;
    byte_t      skid_data;
    logic       halt;
    logic       reply_req;
    err_e       reply_code;
    logic       reply_done;
    audio_cfg_t cfg;

    frame_if frame_bus ();

    // ==================================================
    // Input path
    // ==================================================

    rx_skid u_rx_skid (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (host_valid_i),
        .in_ready_o  (host_ready_o),
        .in_data_i   (host_data_i),
        .out_valid_o (skid_valid),
        .out_ready_i (skid_ready),
        .out_data_o  (skid_data),
        .halt_i      (halt)
    );

    frame_parser u_frame_parser (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_valid_i (skid_valid),
        .in_ready_o (skid_ready),
        .in_data_i  (skid_data),
        .frame      (frame_bus.src)
    );

    // ==================================================
    // Control and reply
    // ==================================================

    stream_ctrl u_stream_ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .frame          (frame_bus.dst),
        .sample_valid_o (sample_valid_o),
        .sample_ready_i (sample_ready_i),
        .sample_data_o  (sample_data_o),
        .cfg_o          (cfg),
        .output_busy_i  (output_busy_i),
        .halt_o         (halt),
        .err_o          (err_o),
        .reply_req_o    (reply_req),
        .reply_code_o   (reply_code),
        .reply_done_i   (reply_done)
    );

    status_reply u_status_reply (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_i         (reply_req),
        .code_i        (reply_code),
        .done_o        (reply_done),
        .reply_valid_o (reply_valid_o),
        .reply_ready_i (reply_ready_i),
        .reply_data_o  (reply_data_o)
    );

    // Config fields out to the pins
    assign io_type_o = cfg.io_type;
    assign rate_o    = cfg.rate;
    assign depth_o   = cfg.depth;

endmodule

// ==== hw/ctrl_pkg.sv ====
/*
 * Types of the playback control path: commands, error codes and the audio
 * configuration. Imported by every block that handles frames or configuration.
 */
`include "ctrl_settings.svh"

package ctrl_pkg;

    // ==================================================
    // Host protocol
    // ==================================================

    typedef logic [`BYTE_W-1:0] byte_t;

    // Command field of the header byte
    typedef enum logic [`CMD_W-1:0] {
        SETUP_OUTPUT  = 2'd0,
        SETUP_INPUT   = 2'd1,
        STREAM_OUTPUT = 2'd2,
        STOP          = 2'd3
    } cmd_e;

    // Second byte of the status reply
    typedef enum logic [`BYTE_W-1:0] {
        NONE          = 8'd0,
        BAD_SETUP_LEN = 8'd1,
        BAD_STOP_LEN  = 8'd2
    } err_e;

    // ==================================================
    // Audio configuration
    // ==================================================

    // One-hot output enable, zero means no output
    typedef logic [1:0] io_type_t;

    localparam io_type_t IO_SPDIF = 2'b01;
    localparam io_type_t IO_I2S   = 2'b10;

    // Bit 2 picks the 48 kHz family, low bits pick 1x..8x
    typedef enum logic [2:0] {
        RATE_44K1  = 3'd0,
        RATE_88K2  = 3'd1,
        RATE_176K4 = 3'd2,
        RATE_352K8 = 3'd3,
        RATE_48K   = 3'd4,
        RATE_96K   = 3'd5,
        RATE_192K  = 3'd6,
        RATE_384K  = 3'd7
    } rate_e;

    typedef enum logic [1:0] {
        DEPTH_DOP = 2'd0,
        DEPTH_16  = 2'd1,
        DEPTH_24  = 2'd2,
        DEPTH_32  = 2'd3
    } depth_e;

    // 7 bits in all
    typedef struct packed {
        io_type_t io_type;
        rate_e    rate;
        depth_e   depth;
    } audio_cfg_t;

endpackage

// ==== hw/ctrl_settings.svh ====
/*
 * Widths and lengths shared by the host control path of the playback controller.
 * Include this wherever a width or length below is needed.
 */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// One host, reply or sample byte
`define BYTE_W 8

// Header layout: command in the top bits, payload length below it
`define CMD_W 2
`define LEN_W 6

// Longest payload that the length field can describe
`define MAX_PAYLOAD ((1 << `LEN_W) - 1)

// Status reply is a header byte plus one code byte
`define REPLY_LEN 2

`endif

// ==== hw/frame_if.sv ====
/*
 * Parsed frame beats from the frame parser to the stream controller.
 * The parser drives the src modport and the controller takes the dst modport.
 */
interface frame_if;
    import ctrl_pkg::*;

    // Handshake
    logic  valid;
    logic  ready;

    // Command of the frame this beat belongs to
    cmd_e  cmd;
    // Whole header byte on a header beat, payload byte otherwise
    byte_t data;
    logic  is_header;
    // Final beat of the frame, also set on a header with length 0
    logic  last;

    modport src (output valid, cmd, data, is_header, last, input ready);

    modport dst (input valid, cmd, data, is_header, last, output ready);

endinterface

// ==== hw/frame_parser.sv ====
/*
 * Splits the host byte stream into frames. Each byte leaves tagged with its
 * command, a header flag and a last flag; command semantics are not checked here.
 */
`include "ctrl_settings.svh"

module frame_parser (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  ctrl_pkg::byte_t in_data_i,
    frame_if.src            frame
);
    import ctrl_pkg::*;

    localparam int CNT_W = $clog2(`MAX_PAYLOAD + 1);

    // Set between a header with payload and its last payload byte
    logic             in_payload_q;
    cmd_e             cmd_q;
    // Payload bytes still to come, including the one on the input
    logic [CNT_W-1:0] remain_q;

    logic             xfer;
    cmd_e             hdr_cmd;
    logic [CNT_W-1:0] hdr_len;

    // Header field split
    assign hdr_cmd = cmd_e'(in_data_i[`BYTE_W-1 -: `CMD_W]);
    assign hdr_len = in_data_i[`LEN_W-1:0];

    // ==================================================
    // Beat tagging, straight from the skid output
    // ==================================================

    assign frame.valid     = in_valid_i;
    assign in_ready_o      = frame.ready;
    assign frame.data      = in_data_i;
    assign frame.is_header = !in_payload_q;
    assign frame.cmd       = in_payload_q ? cmd_q : hdr_cmd;

    // Empty frames end on their header
    assign frame.last = in_payload_q ? (remain_q == CNT_W'(1)) : (hdr_len == '0);

    assign xfer = frame.valid && frame.ready;

    // ==================================================
    // Phase and count
    // ==================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            in_payload_q <= 1'b0;
            cmd_q        <= SETUP_OUTPUT;
            remain_q     <= '0;
        end else if (xfer) begin
            if (!in_payload_q) begin
                // Header with payload opens the payload phase
                if (hdr_len != '0) begin
                    in_payload_q <= 1'b1;
                    cmd_q        <= hdr_cmd;
                    remain_q     <= hdr_len;
                end
            end else begin
                remain_q <= remain_q - CNT_W'(1);
                if (remain_q == CNT_W'(1)) begin
                    in_payload_q <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hw/rx_skid.sv ====
/*
 * Two-entry skid buffer on the host byte input. Keeps host ready off the
 * downstream ready path; halt_i closes the input for good after an error.
 */
module rx_skid (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  ctrl_pkg::byte_t in_data_i,
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output ctrl_pkg::byte_t out_data_o,
    input  logic            halt_i
);
    import ctrl_pkg::*;

    // Head entry is always the one presented downstream
    byte_t      head_q;
    byte_t      tail_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    // Ready only drops once both entries hold a byte
    assign in_ready_o  = (count_q != 2'd2) && !halt_i;
    assign out_valid_o = (count_q != 2'd0);
    assign out_data_o  = head_q;

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            count_q <= 2'd0;
        end else if (push && !pop) begin
            count_q <= count_q + 2'd1;
        end else if (pop && !push) begin
            count_q <= count_q - 2'd1;
        end
    end

    // Byte storage
    always_ff @(posedge clk) begin
        if (push && pop) begin
            // Only reachable with one entry, so the new byte becomes head
            head_q <= in_data_i;
        end else if (push) begin
            if (count_q == 2'd0) begin
                head_q <= in_data_i;
            end else begin
                tail_q <= in_data_i;
            end
        end else if (pop) begin
            head_q <= tail_q;
        end
    end

endmodule

// ==== hw/status_reply.sv ====
/*
 * Sends the two-byte status reply to the host: a stop header with length 1,
 * then the latched code. done_o pulses once the last byte is taken.
 */
`include "ctrl_settings.svh"

module status_reply (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            req_i,
    input  ctrl_pkg::err_e  code_i,
    output logic            done_o,
    output logic            reply_valid_o,
    input  logic            reply_ready_i,
    output ctrl_pkg::byte_t reply_data_o
);
    import ctrl_pkg::*;

    localparam int IDX_W = $clog2(`REPLY_LEN);

    // Header of the reply frame, 0xC1
    localparam byte_t REPLY_HDR = {STOP, `LEN_W'(`REPLY_LEN - 1)};

    logic [IDX_W-1:0] idx_q;
    err_e             code_q;
    logic             last_byte;

    assign last_byte = (idx_q == IDX_W'(`REPLY_LEN - 1));

    // Header first, code after it
    assign reply_data_o = (idx_q == '0) ? REPLY_HDR : byte_t'(code_q);

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            reply_valid_o <= 1'b0;
            idx_q         <= '0;
            done_o        <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!reply_valid_o) begin
                if (req_i) begin
                    reply_valid_o <= 1'b1;
                    idx_q         <= '0;
                end
            end else if (reply_ready_i) begin
                if (last_byte) begin
                    reply_valid_o <= 1'b0;
                    done_o        <= 1'b1;
                end else begin
                    idx_q <= idx_q + IDX_W'(1);
                end
            end
        end
    end

    // Code is held for the whole reply
    always_ff @(posedge clk) begin
        if (!reply_valid_o && req_i) begin
            code_q <= code_i;
        end
    end

endmodule

// ==== hw/stream_ctrl.sv ====
/*
 * Command execution for parsed frames: output setup, sample streaming, stop
 * with the transmitter idle handshake, and the sticky header length error.
 */
`include "ctrl_settings.svh"

module stream_ctrl (
    input  logic                 clk,
    input  logic                 reset_i,
    frame_if.dst                 frame,
    output logic                 sample_valid_o,
    input  logic                 sample_ready_i,
    output ctrl_pkg::byte_t      sample_data_o,
    output ctrl_pkg::audio_cfg_t cfg_o,
    input  logic                 output_busy_i,
    output logic                 halt_o,
    output logic                 err_o,
    output logic                 reply_req_o,
    output ctrl_pkg::err_e       reply_code_o,
    input  logic                 reply_done_i
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_WAIT_IDLE,
        ST_REPLY,
        ST_HALTED
    } state_e;

    state_e            state_q;
    logic              busy_meta_q;
    logic              busy_sync_q;
    logic [`LEN_W-1:0] hdr_len;
    logic              to_output;
    logic              sample_free;
    logic              xfer;
    logic              take_sample;

    assign hdr_len = frame.data[`LEN_W-1:0];

    // Stream payload with an output enabled goes to the sample register
    assign to_output = (frame.cmd == STREAM_OUTPUT) && !frame.is_header
                       && (cfg_o.io_type != '0);

    // Register empty now or emptied on this edge
    assign sample_free = !sample_valid_o || sample_ready_i;

    // Everything else is consumed at once while running
    assign frame.ready = (state_q == ST_RUN) && (!to_output || sample_free);

    assign xfer        = frame.valid && frame.ready;
    assign take_sample = xfer && to_output;

    // Host input closes as soon as the error is raised
    assign halt_o = err_o;

    // Transmitter busy comes from another clock domain
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            busy_meta_q <= 1'b0;
            busy_sync_q <= 1'b0;
        end else begin
            busy_meta_q <= output_busy_i;
            busy_sync_q <= busy_meta_q;
        end
    end

    // ==================================================
    // Sample port
    // ==================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            sample_valid_o <= 1'b0;
        end else if (take_sample) begin
            sample_valid_o <= 1'b1;
        end else if (sample_ready_i) begin
            sample_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_sample) begin
            sample_data_o <= frame.data;
        end
    end

    // ==================================================
    // Command FSM
    // ==================================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q      <= ST_RUN;
            cfg_o        <= '0;
            err_o        <= 1'b0;
            reply_req_o  <= 1'b0;
            reply_code_o <= NONE;
        end else begin
            // Request is a single-cycle pulse
            reply_req_o <= 1'b0;
            case (state_q)
                ST_RUN: begin
                    if (xfer && frame.is_header) begin
                        case (frame.cmd)
                            SETUP_OUTPUT: begin
                                // Exactly one config byte expected
                                if (hdr_len != `LEN_W'(1)) begin
                                    err_o        <= 1'b1;
                                    reply_req_o  <= 1'b1;
                                    reply_code_o <= BAD_SETUP_LEN;
                                    state_q      <= ST_REPLY;
                                end
                            end
                            STOP: begin
                                // A stop header must end its own frame
                                if (frame.last) begin
                                    state_q <= ST_WAIT_IDLE;
                                end else begin
                                    err_o        <= 1'b1;
                                    reply_req_o  <= 1'b1;
                                    reply_code_o <= BAD_STOP_LEN;
                                    state_q      <= ST_REPLY;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end else if (xfer && frame.cmd == SETUP_OUTPUT) begin
                        // Types 0 and 1 map to I2S, 2 and 3 to S/PDIF
                        cfg_o.io_type <= frame.data[`BYTE_W-1] ? IO_SPDIF : IO_I2S;
                        cfg_o.rate    <= rate_e'(frame.data[4:2]);
                        cfg_o.depth   <= depth_e'(frame.data[1:0]);
                    end
                end
                ST_WAIT_IDLE: begin
                    if (!busy_sync_q) begin
                        reply_req_o  <= 1'b1;
                        reply_code_o <= NONE;
                        state_q      <= ST_REPLY;
                    end
                end
                ST_REPLY: begin
                    if (reply_done_i) begin
                        state_q <= err_o ? ST_HALTED : ST_RUN;
                    end
                end
                default: begin
                    // Halted until reset
                    state_q <= ST_HALTED;
                end
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing -f build.f --top-module tb_audio_ctrl -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > "$LOG" 2>&1 \
    || { echo "Build or simulation did not complete"; cat "$LOG" 2>/dev/null; exit 1; }
cat "$LOG"
grep -q "TEST RESULT: FAIL" "$LOG" && exit 1
grep -q "TEST RESULT: PASS" "$LOG" || exit 1
exit 0

// ==== test/tb_audio_ctrl.sv ====
/*
 * Directed testbench for the playback host control path. Sends host frames,
 * collects samples and status replies under random back-pressure and checks them.
 */
module tb_audio_ctrl;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;
    // Longest wait for a sample or reply byte
    localparam int WAIT_LIMIT      = 1000;

    logic     clk;
    logic     reset_i;
    logic     host_valid_i;
    logic     host_ready_o;
    byte_t    host_data_i;
    logic     reply_valid_o;
    logic     reply_ready_i;
    byte_t    reply_data_o;
    logic     sample_valid_o;
    logic     sample_ready_i;
    byte_t    sample_data_o;
    io_type_t io_type_o;
    rate_e    rate_o;
    depth_e   depth_o;
    logic     output_busy_i;
    logic     err_o;

    integer   seed;
    integer   ready_rnd;
    int       checks;
    int       mismatches;
    int       failures;

    // Bytes after the header of the next frame sent
    byte_t    payload_q[$];
    // Bytes seen leaving the DUT
    byte_t    samples_q[$];
    byte_t    reply_q[$];

    audio_ctrl_top DUT (
        .clk            (clk),
        .reset_i        (reset_i),
        .host_valid_i   (host_valid_i),
        .host_ready_o   (host_ready_o),
        .host_data_i    (host_data_i),
        .reply_valid_o  (reply_valid_o),
        .reply_ready_i  (reply_ready_i),
        .reply_data_o   (reply_data_o),
        .sample_valid_o (sample_valid_o),
        .sample_ready_i (sample_ready_i),
        .sample_data_o  (sample_data_o),
        .io_type_o      (io_type_o),
        .rate_o         (rate_o),
        .depth_o        (depth_o),
        .output_busy_i  (output_busy_i),
        .err_o          (err_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Random back-pressure on both output ports
    always @(posedge clk) begin
        ready_rnd = $random(seed);
        sample_ready_i <= ready_rnd[0];
        reply_ready_i  <= ready_rnd[1];
    end

    // Handshakes seen mid-cycle complete on the next rising edge
    always @(negedge clk) begin
        if (!reset_i) begin
            if (sample_valid_o && sample_ready_i) begin
                samples_q.push_back(sample_data_o);
            end
            if (reply_valid_o && reply_ready_i) begin
                reply_q.push_back(reply_data_o);
            end
        end
    end

    // ==================================================
    // Compare tasks and expected values
    // ==================================================

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_cfg(input string name, input audio_cfg_t got, input audio_cfg_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Command in bits 7:6 and payload length in bits 5:0
    function automatic byte_t make_header(input cmd_e cmd, input logic [5:0] len);
        return {cmd, len};
    endfunction

    function automatic audio_cfg_t expected_cfg(input byte_t setting);
        audio_cfg_t cfg;
        // Output types 0 and 1 are I2S on bit 1, types 2 and 3 S/PDIF on bit 0
        if (setting[7:6] <= 2'd1) begin
            cfg.io_type = 2'b10;
        end else begin
            cfg.io_type = 2'b01;
        end
        cfg.rate  = rate_e'(setting[4:2]);
        cfg.depth = depth_e'(setting[1:0]);
        return cfg;
    endfunction

    function automatic audio_cfg_t current_cfg();
        audio_cfg_t cfg;
        cfg.io_type = io_type_o;
        cfg.rate    = rate_o;
        cfg.depth   = depth_o;
        return cfg;
    endfunction

    // ==================================================
    // Stimulus helpers
    // ==================================================

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        samples_q.delete();
        reply_q.delete();
    endtask

    // Starts on a rising edge and returns on the edge that takes the byte
    task automatic send_byte(input byte_t value);
        host_valid_i <= 1'b1;
        host_data_i  <= value;
        @(negedge clk);
        while (!host_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // Header first, then every byte of payload_q back to back
    task automatic send_frame(input byte_t header);
        @(posedge clk);
        send_byte(header);
        foreach (payload_q[i]) begin
            send_byte(payload_q[i]);
        end
        host_valid_i <= 1'b0;
    endtask

    task automatic wait_samples(input int count);
        int cycles;
        cycles = 0;
        while (samples_q.size() < count && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (samples_q.size() < count) begin
            failures++;
            $display("Timed out waiting for %0d samples, only %0d arrived",
                     count, samples_q.size());
        end
    endtask

    // Waits for both reply bytes and checks them
    task automatic expect_reply(input byte_t code);
        int cycles;
        cycles = 0;
        while (reply_q.size() < 2 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (reply_q.size() < 2) begin
            failures++;
            $display("Timed out waiting for the status reply, got %0d bytes", reply_q.size());
        end else begin
            check_byte("reply_data_o header", reply_q[0], make_header(STOP, 6'd1));
            check_byte("reply_data_o code", reply_q[1], code);
        end
        idle(10);
        if (reply_q.size() > 2) begin
            failures++;
            $display("Status reply carried %0d bytes instead of 2", reply_q.size());
        end
    endtask

    task automatic setup_output(input byte_t setting);
        payload_q.delete();
        payload_q.push_back(setting);
        send_frame(make_header(SETUP_OUTPUT, 6'd1));
        idle(4);
        @(negedge clk);
        check_cfg("cfg", current_cfg(), expected_cfg(setting));
    endtask

    // Random stream frame where delivered expects every byte back in order
    task automatic stream_frame(input int count, input logic delivered);
        integer rnd;
        payload_q.delete();
        samples_q.delete();
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            payload_q.push_back(byte_t'(rnd));
        end
        send_frame(make_header(STREAM_OUTPUT, 6'(count)));
        if (delivered) begin
            wait_samples(count);
            if (samples_q.size() >= count) begin
                for (int i = 0; i < count; i++) begin
                    check_byte($sformatf("sample_data_o[%0d]", i), samples_q[i], payload_q[i]);
                end
            end
            idle(10);
            if (samples_q.size() > count) begin
                failures++;
                $display("Stream of %0d bytes produced %0d samples", count, samples_q.size());
            end
        end else begin
            idle(20);
            if (samples_q.size() != 0) begin
                failures++;
                $display("Samples appeared with no output selected, %0d in all",
                         samples_q.size());
            end
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_after_reset();
        @(negedge clk);
        check_byte("io_type_o", {6'd0, io_type_o}, 8'h00);
        check_flag("err_o", err_o, 1'b0);
        check_flag("sample_valid_o", sample_valid_o, 1'b0);
        check_flag("reply_valid_o", reply_valid_o, 1'b0);
        check_flag("host_ready_o", host_ready_o, 1'b1);
    endtask

    task automatic test_setup_and_stream();
        setup_output(8'h55);
        stream_frame(40, 1'b1);
    endtask

    task automatic test_no_output_and_setup_input();
        apply_reset();
        stream_frame(4, 1'b0);
        setup_output(8'h9A);
        // Setup-input payload is swallowed
        payload_q.delete();
        payload_q.push_back(8'h12);
        payload_q.push_back(8'hFF);
        payload_q.push_back(8'h00);
        send_frame(make_header(SETUP_INPUT, 6'd3));
        idle(6);
        @(negedge clk);
        check_cfg("cfg after setup-input", current_cfg(), expected_cfg(8'h9A));
        stream_frame(8, 1'b1);
    endtask

    task automatic test_stop();
        setup_output(8'h55);
        @(posedge clk);
        output_busy_i <= 1'b1;
        idle(4);
        reply_q.delete();
        payload_q.delete();
        send_frame(8'hC0);
        idle(50);
        if (reply_q.size() != 0) begin
            failures++;
            $display("Status reply sent while the transmitter was busy");
        end
        @(posedge clk);
        output_busy_i <= 1'b0;
        expect_reply(8'h00);
        @(negedge clk);
        check_flag("err_o", err_o, 1'b0);
        stream_frame(6, 1'b1);
    endtask

    task automatic test_bad_setup_len();
        reply_q.delete();
        payload_q.delete();
        send_frame(make_header(SETUP_OUTPUT, 6'd2));
        expect_reply(8'h01);
        @(negedge clk);
        check_flag("err_o", err_o, 1'b1);
        check_flag("host_ready_o", host_ready_o, 1'b0);
        idle(20);
        @(negedge clk);
        check_flag("host_ready_o after halt", host_ready_o, 1'b0);
        apply_reset();
        test_after_reset();
    endtask

    task automatic test_bad_stop_len();
        reply_q.delete();
        payload_q.delete();
        send_frame(make_header(STOP, 6'd1));
        expect_reply(8'h02);
        @(negedge clk);
        check_flag("err_o", err_o, 1'b1);
        apply_reset();
    endtask

    // ==================================================
    // Sequence, watchdog and summary
    // ==================================================

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        reset_i        <= 1'b1;
        host_valid_i   <= 1'b0;
        host_data_i    <= 8'h00;
        reply_ready_i  <= 1'b0;
        sample_ready_i <= 1'b0;
        output_busy_i  <= 1'b0;
        seed           = 66;
        checks         = 0;
        mismatches     = 0;
        failures       = 0;
        apply_reset();
        test_after_reset();
        test_setup_and_stream();
        test_no_output_and_setup_input();
        test_stop();
        test_bad_setup_len();
        test_bad_stop_len();
        $display("Summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
